// File: axil_pkg.sv
package axil_pkg;

    // AXI4-Lite write side widths
    localparam int ADDR_W   = 7;  // Byte address, index times 4
    localparam int RESP_W   = 2;  // BRESP field
    localparam int STRB_W   = 4;  // One strobe bit per data byte
    localparam int ADDR_LSB = 2;  // Word aligned, low bits always zero

    typedef logic [ADDR_W-1:0] axil_addr_t;  // AW channel address
    typedef logic [RESP_W-1:0] axil_resp_t;  // B channel response

    typedef logic [STRB_W-1:0] axil_strb_t;  // W channel byte strobes

    // Response codes
    localparam axil_resp_t RESP_OKAY   = 2'd0;  // Write accepted
    localparam axil_resp_t RESP_SLVERR = 2'd2;  // Slave rejected the write

    // All bytes of a word are written together
    localparam axil_strb_t STRB_ALL = '1;

endpackage

// File: axil_write_master.sv
`timescale 1ns/1ns

module axil_write_master (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     pop_valid,   // FIFO has an entry
    input  esp_link_pkg::reg_index_t pop_index,
    input  esp_link_pkg::reg_word_t  pop_data,
    input  logic                     awready,
    input  logic                     wready,
    input  logic                     bvalid,
    input  axil_pkg::axil_resp_t     bresp,
    output logic                     pop_ready,   // Idle and able to start
    output logic                     awvalid,
    output axil_pkg::axil_addr_t     awaddr,
    output logic                     wvalid,
    output esp_link_pkg::reg_word_t  wdata,
    output axil_pkg::axil_strb_t     wstrb,
    output logic                     bready,
    output logic                     resp_error   // Sticky, any non OKAY response
);

    typedef enum logic [1:0] {
        ST_IDLE,       // Waiting for a FIFO entry
        ST_ADDR_DATA,  // AW and W offered
        ST_RESP        // Waiting for B
    } state_t;

    state_t state;
    logic   aw_done;   // AW handshake already seen
    logic   w_done;    // W handshake already seen
    logic   pop_fire;
    logic   aw_fire;
    logic   w_fire;
    logic   b_fire;
    logic   aw_ok;     // AW finished now or earlier
    logic   w_ok;      // W finished now or earlier

    // Channel valids decoded from state, low in reset
    assign pop_ready = (state == ST_IDLE);
    assign awvalid   = (state == ST_ADDR_DATA) && !aw_done;
    assign wvalid    = (state == ST_ADDR_DATA) && !w_done;
    assign bready    = (state == ST_RESP);
    assign wstrb     = axil_pkg::STRB_ALL;  // Full word writes only

    assign pop_fire = pop_valid && pop_ready;
    assign aw_fire  = awvalid && awready;
    assign w_fire   = wvalid && wready;
    assign b_fire   = bvalid && bready;

    assign aw_ok = aw_done || aw_fire;  // AW and W may finish in either order
    assign w_ok  = w_done || w_fire;

    // Payload captured at pop, stable until the next pop
    always_ff @(posedge clk) begin
        if (pop_fire) begin
            awaddr <= {pop_index, {axil_pkg::ADDR_LSB{1'b0}}};  // Index times 4
            wdata  <= pop_data;
        end
    end

    // One write outstanding at a time
    always_ff @(posedge clk) begin
        if (!nrst) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (pop_fire) begin
                        state <= ST_ADDR_DATA;  // Valids rise next cycle
                    end
                end
                ST_ADDR_DATA: begin
                    aw_done <= aw_ok;
                    w_done  <= w_ok;
                    if (aw_ok && w_ok) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (b_fire) begin
                        state <= ST_IDLE;  // Next entry only after B
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Error flag stays set until reset
    always_ff @(posedge clk) begin
        if (!nrst) begin
            resp_error <= 1'b0;
        end else if (b_fire && (bresp != axil_pkg::RESP_OKAY)) begin
            resp_error <= 1'b1;
        end
    end

endmodule

// File: esp_link_pkg.sv
package esp_link_pkg;

    // Field widths of the stream side
    localparam int BYTE_W  = 8;           // One host byte
    localparam int WORD_W  = 32;          // One register word
    localparam int INDEX_W = 5;           // Register index, 32 registers
    localparam int DROP_W  = 16;          // Saturating drop counter

    typedef logic [BYTE_W-1:0]  esp_byte_t;   // Byte from the ESP32 stream
    typedef logic [WORD_W-1:0]  reg_word_t;   // Packed register word
    typedef logic [INDEX_W-1:0] reg_index_t;  // Target register number
    typedef logic [DROP_W-1:0]  drop_count_t; // Words lost on a full FIFO

    // Packing of bytes into words
    localparam int BYTES_PER_WORD = 4;                              // MSB first
    localparam int CNT_W          = $clog2(BYTES_PER_WORD);         // Byte counter
    localparam int PART_W         = (BYTES_PER_WORD - 1) * BYTE_W;  // Bytes held back

    // Register 0 is never written; indexes run 1..31 and wrap
    localparam reg_index_t FIRST_INDEX = 5'd1;
    localparam reg_index_t LAST_INDEX  = 5'd31;

    // Default entry count of the word FIFO
    localparam int FIFO_DEPTH = 4;

    // Last byte position in a word
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BYTES_PER_WORD - 1);

    // Byte counter value at the start of a word
    localparam logic [CNT_W-1:0] FIRST_BYTE = '0;

endpackage

// File: esp_reg_bridge.sv
`timescale 1ns/1ns

module esp_reg_bridge (
    input  logic                      clk,
    input  logic                      nrst,
    input  esp_link_pkg::esp_byte_t   esp_data,    // Host byte stream
    input  logic                      esp_valid,
    output esp_link_pkg::drop_count_t drop_count,  // Words lost to a full FIFO
    output logic                      awvalid,     // AXI4-Lite write master
    input  logic                      awready,
    output axil_pkg::axil_addr_t      awaddr,
    output logic                      wvalid,
    input  logic                      wready,
    output esp_link_pkg::reg_word_t   wdata,
    output axil_pkg::axil_strb_t      wstrb,
    input  logic                      bvalid,
    output logic                      bready,
    input  axil_pkg::axil_resp_t      bresp,
    output logic                      resp_error   // Sticky slave error
);

    // Producer to FIFO
    logic                     push_valid;
    logic                     push_ready;
    esp_link_pkg::reg_index_t push_index;
    esp_link_pkg::reg_word_t  push_data;

    // FIFO to consumer
    logic                     pop_valid;
    logic                     pop_ready;
    esp_link_pkg::reg_index_t pop_index;
    esp_link_pkg::reg_word_t  pop_data;

    // Packs bytes and drops words when the FIFO is full
    esp_word_assembler u_assembler (
        .clk        (clk),
        .nrst       (nrst),
        .esp_data   (esp_data),
        .esp_valid  (esp_valid),
        .push_ready (push_ready),
        .push_valid (push_valid),
        .push_index (push_index),
        .push_data  (push_data),
        .drop_count (drop_count)
    );

    // Absorbs slave back-pressure
    word_fifo #(
        .DEPTH (esp_link_pkg::FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .nrst       (nrst),
        .push_valid (push_valid),
        .push_index (push_index),
        .push_data  (push_data),
        .pop_ready  (pop_ready),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_index  (pop_index),
        .pop_data   (pop_data)
    );

    // Turns entries into AXI4-Lite writes
    axil_write_master u_master (
        .clk        (clk),
        .nrst       (nrst),
        .pop_valid  (pop_valid),
        .pop_index  (pop_index),
        .pop_data   (pop_data),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .pop_ready  (pop_ready),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bready     (bready),
        .resp_error (resp_error)
    );

endmodule

// File: esp_reg_bridge_checker.sv
`timescale 1ns/1ns

module esp_reg_bridge_checker (
    input logic                    clk,
    input logic                    nrst,
    input logic                    push_fire,   // Accepted FIFO push
    input logic                    fifo_full,
    input logic                    pop_fire,    // Accepted FIFO pop
    input logic                    fifo_empty,
    input logic                    awvalid,
    input logic                    awready,
    input axil_pkg::axil_addr_t    awaddr,
    input logic                    wvalid,
    input logic                    wready,
    input esp_link_pkg::reg_word_t wdata,
    input logic                    bvalid,
    input logic                    bready
);

    int   assert_failures;  // Read by the testbench at the end
    logic b_pending;        // AW accepted and B not seen yet

    initial assert_failures = 0;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            b_pending <= 1'b0;
        end else if (bvalid && bready) begin
            b_pending <= 1'b0;
        end else if (awvalid && awready) begin
            b_pending <= 1'b1;
        end
    end

    aw_stable: assert property (@(posedge clk) disable iff (!nrst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("AW dropped or changed before its handshake");
            assert_failures++;
        end

    w_stable: assert property (@(posedge clk) disable iff (!nrst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else begin
            $error("W dropped or changed before its handshake");
            assert_failures++;
        end

    // A full FIFO that is not popped stays full, so no push got in
    no_push_full: assert property (@(posedge clk) disable iff (!nrst)
        fifo_full && !pop_fire |=> fifo_full)
        else begin
            $error("Entry written into a full FIFO");
            assert_failures++;
        end

    // An empty FIFO that is not pushed stays empty, so no pop got out
    no_pop_empty: assert property (@(posedge clk) disable iff (!nrst)
        fifo_empty && !push_fire |=> fifo_empty)
        else begin
            $error("Entry read from an empty FIFO");
            assert_failures++;
        end

    one_outstanding: assert property (@(posedge clk) disable iff (!nrst) b_pending |-> !awvalid)
        else begin
            $error("New AW issued before the B handshake");
            assert_failures++;
        end

endmodule

// FIFO side with the AXI ports tied off
bind word_fifo esp_reg_bridge_checker fifo_chk (
    .clk(clk), .nrst(nrst),
    .push_fire(do_push), .fifo_full(count == DEPTH),
    .pop_fire(do_pop), .fifo_empty(count == 0),
    .awvalid(1'b0), .awready(1'b0), .awaddr('0),
    .wvalid(1'b0), .wready(1'b0), .wdata('0),
    .bvalid(1'b0), .bready(1'b0)
);

// AXI side with the FIFO ports tied off
bind axil_write_master esp_reg_bridge_checker master_chk (
    .clk(clk), .nrst(nrst),
    .push_fire(1'b0), .fifo_full(1'b0), .pop_fire(1'b0), .fifo_empty(1'b0),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata),
    .bvalid(bvalid), .bready(bready)
);

// File: esp_word_assembler.sv
`timescale 1ns/1ns

module esp_word_assembler (
    input  logic                      clk,
    input  logic                      nrst,
    input  esp_link_pkg::esp_byte_t   esp_data,    // Byte from host
    input  logic                      esp_valid,   // Byte strobe
    input  logic                      push_ready,  // FIFO has room
    output logic                      push_valid,  // One cycle per word
    output esp_link_pkg::reg_index_t  push_index,  // Target register
    output esp_link_pkg::reg_word_t   push_data,   // Assembled word
    output esp_link_pkg::drop_count_t drop_count   // Words lost on full FIFO
);

    logic [esp_link_pkg::CNT_W-1:0]  byte_cnt;   // Bytes taken in current word
    logic [esp_link_pkg::PART_W-1:0] shift_reg;  // Earlier bytes of the word
    esp_link_pkg::reg_index_t        cur_index;  // Index for the next word
    esp_link_pkg::reg_index_t        next_index; // Index after wrap
    logic                            word_done;  // Last byte arriving now
    logic                            drop_now;   // Word offered but refused

    assign word_done = esp_valid && (byte_cnt == esp_link_pkg::LAST_BYTE);
    assign drop_now  = push_valid && !push_ready;

    // Index 31 wraps back to 1, register 0 is skipped
    always_comb begin
        if (cur_index == esp_link_pkg::LAST_INDEX) begin
            next_index = esp_link_pkg::FIRST_INDEX;
        end else begin
            next_index = esp_link_pkg::reg_index_t'(cur_index + 1'b1);
        end
    end

    // Byte counter and index, control state
    always_ff @(posedge clk) begin
        if (!nrst) begin
            byte_cnt   <= esp_link_pkg::FIRST_BYTE;
            cur_index  <= esp_link_pkg::FIRST_INDEX;  // First word goes to reg 1
            push_valid <= 1'b0;
        end else begin
            push_valid <= word_done;  // Pulse the cycle after the fourth byte
            if (esp_valid) begin
                if (word_done) begin
                    byte_cnt  <= esp_link_pkg::FIRST_BYTE;
                    cur_index <= next_index;  // Advances even if the word is dropped
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // Payload path, MSB first
    always_ff @(posedge clk) begin
        if (esp_valid) begin
            shift_reg <= {shift_reg[esp_link_pkg::PART_W-esp_link_pkg::BYTE_W-1:0],
                          esp_data};  // Oldest byte moves up
        end
        if (word_done) begin
            push_data  <= {shift_reg, esp_data};  // Last byte is the LSB
            push_index <= cur_index;
        end
    end

    // Stream cannot stall, so a refused word is only counted
    always_ff @(posedge clk) begin
        if (!nrst) begin
            drop_count <= '0;
        end else if (drop_now && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;  // Holds at all ones
        end
    end

endmodule

// File: tb_esp_reg_bridge.sv
`timescale 1ns/1ns

module tb_esp_reg_bridge;

    localparam int          CLK_HALF    = 4;         // 8 ns period
    localparam logic [15:0] LFSR_SEED   = 16'd35658;
    localparam logic [15:0] LFSR_TAPS   = 16'hB400;  // x^16+x^14+x^13+x^11+1
    localparam int          DRAIN_LIMIT = 5000;      // Cycles per drain
    localparam int          ERR_ADDR    = 17 * 4;    // Rejected register in the error phase

    logic                      clk;
    logic                      nrst;
    esp_link_pkg::esp_byte_t   esp_data;
    logic                      esp_valid;
    esp_link_pkg::drop_count_t drop_count;
    logic                      awvalid;
    logic                      awready;
    axil_pkg::axil_addr_t      awaddr;
    logic                      wvalid;
    logic                      wready;
    esp_link_pkg::reg_word_t   wdata;
    axil_pkg::axil_strb_t      wstrb;
    logic                      bvalid;
    logic                      bready;
    axil_pkg::axil_resp_t      bresp;
    logic                      resp_error;

    logic [15:0]             lfsr;           // Shared stimulus LFSR
    esp_link_pkg::esp_byte_t sent_bytes [$]; // Every byte driven in stream order
    logic [31:0]             got_addr_q [$]; // Completed writes from the slave
    logic [31:0]             got_data_q [$];
    int                      mismatches;
    int                      failures;
    int                      writes_seen;
    int                      next_pos;       // Next stream word to match
    int                      skipped;        // Stream words never written
    logic                    skip_ok;        // Drops expected in this phase
    logic                    err_enable;     // Slave rejects ERR_ADDR
    logic                    err_done;       // Rejected B already completed
    int                      ready_bits;     // Ready 1 in 2**n, always for 0
    int                      bvalid_bits;

    esp_reg_bridge UUT (
        .clk(clk), .nrst(nrst), .esp_data(esp_data), .esp_valid(esp_valid),
        .drop_count(drop_count), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp), .resp_error(resp_error)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};  // One step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic ready_draw(input int bits, output logic v);
        logic [15:0] r;
        if (bits == 0) begin
            v = 1'b1;
        end else begin
            draw_bits(bits, r);
            v = (r == 16'd0);
        end
    endtask

    function automatic int word_count();
        return sent_bytes.size() / esp_link_pkg::BYTES_PER_WORD;
    endfunction

    // Expected {index, word} of stream word k
    function automatic logic [36:0] reference_entry(input int k);
        logic [4:0]  exp_index;
        logic [31:0] exp_word;
        int          span;
        span      = esp_link_pkg::LAST_INDEX - esp_link_pkg::FIRST_INDEX + 1;  // 31 targets
        exp_index = 5'(esp_link_pkg::FIRST_INDEX + (k % span));
        exp_word  = '0;
        for (int b = 0; b < esp_link_pkg::BYTES_PER_WORD; b++) begin
            exp_word = {exp_word[23:0], sent_bytes[k * 4 + b]};  // First byte ends up on top
        end
        return {exp_index, exp_word};
    endfunction

    function automatic logic entry_matches(input int k, input logic [31:0] addr,
                                           input logic [31:0] data);
        logic [36:0] entry;
        entry = reference_entry(k);
        return (addr == {25'd0, entry[36:32], 2'b00}) && (data == entry[31:0]);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
            mismatches++;
        end
    endtask

    task automatic finish_run();
        int asserts;
        asserts = UUT.u_fifo.fifo_chk.assert_failures + UUT.u_master.master_chk.assert_failures;
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, asserts);
        if (mismatches + failures + asserts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Sends count words with gap_min plus random idle cycles after each byte
    task automatic send_words(input int count, input int gap_min, input int gap_bits);
        logic [15:0] r;
        int          gap;
        for (int n = 0; n < count * esp_link_pkg::BYTES_PER_WORD; n++) begin
            draw_bits(8, r);
            next_cycle();
            esp_data  = r[7:0];
            esp_valid = 1'b1;
            sent_bytes.push_back(r[7:0]);
            gap = gap_min;
            if (gap_bits > 0) begin
                draw_bits(gap_bits, r);
                gap += int'(r);
            end
            repeat (gap) begin
                next_cycle();
                esp_valid = 1'b0;
            end
        end
        next_cycle();
        esp_valid = 1'b0;
    endtask

    // Every word is either written or counted as dropped
    task automatic drain(input string phase);
        int cycles;
        cycles = 0;
        while ((writes_seen + int'(drop_count) != word_count() || got_addr_q.size() != 0)
               && cycles < DRAIN_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (cycles >= DRAIN_LIMIT) begin
            $display("Timeout: writes of the %s phase never completed", phase);
            failures++;
            finish_run();
        end
    endtask

    // AXI4-Lite slave that samples at negedge and drives after posedge
    initial begin : axil_slave
        logic                 aw_got;
        logic                 w_got;
        logic [31:0]          cur_addr;
        logic [31:0]          cur_data;
        logic                 awready_nx;
        logic                 wready_nx;
        logic                 bvalid_nx;
        axil_pkg::axil_resp_t bresp_nx;
        aw_got = 1'b0;
        w_got  = 1'b0;
        awready_nx = 1'b0;
        wready_nx  = 1'b0;
        bvalid_nx  = 1'b0;
        bresp_nx   = axil_pkg::RESP_OKAY;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = axil_pkg::RESP_OKAY;
        forever begin
            @(negedge clk);
            if (nrst === 1'b1) begin
                check_value("resp_error", resp_error, err_done);
                if (awvalid && awready) begin
                    aw_got   = 1'b1;
                    cur_addr = 32'(awaddr);
                end
                if (wvalid && wready) begin
                    w_got    = 1'b1;
                    cur_data = wdata;
                    check_value("wstrb", 32'(wstrb), 32'hF);  // Whole word every time
                end
                if (bvalid && bready) begin
                    got_addr_q.push_back(cur_addr);  // Write completes at this edge
                    got_data_q.push_back(cur_data);
                    writes_seen++;
                    if (bresp == axil_pkg::RESP_SLVERR) begin
                        err_done = 1'b1;
                    end
                    aw_got    = 1'b0;
                    w_got     = 1'b0;
                    bvalid_nx = 1'b0;
                end else if (!bvalid && aw_got && w_got) begin
                    ready_draw(bvalid_bits, bvalid_nx);  // Random B delay
                    bresp_nx = (err_enable && cur_addr == ERR_ADDR) ?
                               axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
                end
                ready_draw(ready_bits, awready_nx);
                ready_draw(ready_bits, wready_nx);
            end
            next_cycle();
            awready = awready_nx;
            wready  = wready_nx;
            bvalid  = bvalid_nx;
            bresp   = bresp_nx;
        end
    end

    // Matches each completed write against the reference stream
    initial begin : compare_writes
        logic [36:0] entry;
        logic [31:0] addr;
        logic [31:0] data;
        int          pos;
        forever begin
            @(negedge clk);
            while (got_addr_q.size() != 0) begin
                addr = got_addr_q.pop_front();
                data = got_data_q.pop_front();
                if (addr == 32'd0) begin
                    $display("A write went to address 0, which is never a target");
                    failures++;
                end
                if (skip_ok) begin
                    pos = next_pos;
                    while (pos < word_count() && !entry_matches(pos, addr, data)) begin
                        pos++;
                    end
                    if (pos < word_count()) begin
                        skipped += pos - next_pos;  // Words lost to a full FIFO
                        next_pos = pos;
                    end
                end
                if (next_pos >= word_count()) begin
                    $display("A write arrived with no stream word left to match it");
                    failures++;
                end else begin
                    entry = reference_entry(next_pos);
                    check_value("awaddr", addr, {25'd0, entry[36:32], 2'b00});
                    check_value("wdata", data, entry[31:0]);
                end
                next_pos++;
            end
        end
    end

    initial begin : main_flow
        nrst = 1'b0;
        esp_data = '0;
        esp_valid = 1'b0;
        lfsr = LFSR_SEED;
        mismatches = 0;
        failures = 0;
        writes_seen = 0;
        next_pos = 0;
        skipped = 0;
        skip_ok = 1'b0;
        err_enable = 1'b0;
        err_done = 1'b0;
        ready_bits = 0;
        bvalid_bits = 0;
        repeat (3) @(posedge clk);
        #1;
        check_value("push_valid", UUT.push_valid, 0);
        check_value("pop_valid", UUT.pop_valid, 0);
        check_value("awvalid", awvalid, 0);
        check_value("wvalid", wvalid, 0);
        check_value("bready", bready, 0);
        check_value("resp_error", resp_error, 0);
        check_value("drop_count", drop_count, 0);
        nrst = 1'b1;

        send_words(8, 1, 0);     // Slave always ready with a steady stream
        drain("in-order");
        check_value("drop_count", drop_count, skipped);

        send_words(36, 1, 0);    // Index runs past 31 and wraps to 1
        drain("index wrap");
        check_value("drop_count", drop_count, skipped);

        ready_bits  = 1;         // Ready half the time
        bvalid_bits = 1;
        send_words(24, 2, 2);
        drain("random delay");
        check_value("drop_count", drop_count, skipped);

        ready_bits  = 3;         // Heavy stalls with back-to-back bytes
        bvalid_bits = 3;
        skip_ok     = 1'b1;
        send_words(30, 0, 0);
        drain("heavy stall");
        skipped += word_count() - next_pos;  // Dropped words at the tail
        next_pos = word_count();
        skip_ok  = 1'b0;
        check_value("drop_count", drop_count, skipped);
        if (skipped == 0) begin
            $display("The heavy stall phase dropped no words, FIFO never filled");
            failures++;
        end

        ready_bits  = 0;
        bvalid_bits = 0;
        err_enable  = 1'b1;      // Register 17 answers SLVERR
        send_words(31, 1, 0);
        drain("error response");
        check_value("resp_error", resp_error, 1);
        check_value("drop_count", drop_count, skipped);
        finish_run();
    end

endmodule

// File: vlog.f
esp_link_pkg.sv
axil_pkg.sv
esp_word_assembler.sv
word_fifo.sv
axil_write_master.sv
esp_reg_bridge.sv
esp_reg_bridge_checker.sv
tb_esp_reg_bridge.sv

// File: word_fifo.sv
`timescale 1ns/1ns

module word_fifo #(
    parameter int DEPTH = esp_link_pkg::FIFO_DEPTH
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     push_valid,  // Word offered by producer
    input  esp_link_pkg::reg_index_t push_index,
    input  esp_link_pkg::reg_word_t  push_data,
    input  logic                     pop_ready,   // Consumer takes head entry
    output logic                     push_ready,  // Not full
    output logic                     pop_valid,   // Not empty
    output esp_link_pkg::reg_index_t pop_index,
    output esp_link_pkg::reg_word_t  pop_data
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;    // Slot number
    typedef logic [$clog2(DEPTH+1)-1:0] count_t;  // 0..DEPTH entries

    esp_link_pkg::reg_index_t index_mem [DEPTH];  // Index of each slot
    esp_link_pkg::reg_word_t  data_mem  [DEPTH];  // Word of each slot

    ptr_t   wr_ptr;   // Next slot to fill
    ptr_t   rd_ptr;   // Head of the queue
    count_t count;    // Occupancy
    logic   do_push;
    logic   do_pop;

    // Flags straight from the occupancy count
    assign push_ready = (count != count_t'(DEPTH));
    assign pop_valid  = (count != '0);

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    // Head entry shown without a register stage
    assign pop_index = index_mem[rd_ptr];
    assign pop_data  = data_mem[rd_ptr];

    // Storage, written only on an accepted push
    always_ff @(posedge clk) begin
        if (do_push) begin
            index_mem[wr_ptr] <= push_index;
            data_mem[wr_ptr]  <= push_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;  // Push only
                2'b01:   count <= count - 1'b1;  // Pop only
                default: count <= count;         // Both or neither
            endcase
        end
    end

endmodule
